//--- src/periph_pkg.sv
/*
  Peripheral subsystem package: address map, register offsets,
  interrupt source layout and shared enums
*/
`default_nettype none

package periph_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Register offset field; the peripheral select sits just above it
  localparam int OFF_W = 12;

  localparam int GPIO_W = 8;

  // Interrupt source layout, source 0 is reserved
  localparam int NUM_SRC       = 16;
  localparam int SRC_ID_W      = 4;
  localparam int GPIO_IRQ_BASE = 1;
  localparam int EXT_IRQ_BASE  = 9;

  typedef enum logic [1:0] {
    SEL_PLIC  = 2'd0,
    SEL_GPIO  = 2'd1,
    SEL_TIMER = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
  } bridge_state_e;

  // PLIC
  localparam logic [OFF_W-1:0] PLIC_PENDING = 'h0;
  localparam logic [OFF_W-1:0] PLIC_ENABLE  = 'h4;
  localparam logic [OFF_W-1:0] PLIC_CLAIM   = 'h8;
  localparam logic [OFF_W-1:0] PLIC_MSIP    = 'hC;

  // GPIO
  localparam logic [OFF_W-1:0] GPIO_IN         = 'h0;
  localparam logic [OFF_W-1:0] GPIO_OUT        = 'h4;
  localparam logic [OFF_W-1:0] GPIO_OE         = 'h8;
  localparam logic [OFF_W-1:0] GPIO_INTR_EN    = 'hC;
  localparam logic [OFF_W-1:0] GPIO_INTR_STATE = 'h10;

  // Timer
  localparam logic [OFF_W-1:0] TMR_CTRL     = 'h0;
  localparam logic [OFF_W-1:0] TMR_PRESCALE = 'h4;
  localparam logic [OFF_W-1:0] TMR_COUNT    = 'h8;
  localparam logic [OFF_W-1:0] TMR_CMP0     = 'hC;
  localparam logic [OFF_W-1:0] TMR_CMP1     = 'h10;

endpackage

`default_nettype wire

//--- src/obi_reg_bridge.sv
/*
  OBI slave to register bridge, non-pipelined: one request at a time
  becomes a single-cycle register strobe, read data returns with rvalid
*/
`default_nettype none

module obi_reg_bridge (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [periph_pkg::ADDR_W-1:0] addr_i,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,
  output logic                          reg_valid_o,
  output logic                          reg_write_o,
  output logic [periph_pkg::ADDR_W-1:0] reg_addr_o,
  output logic [periph_pkg::DATA_W-1:0] reg_wdata_o,
  input  logic [periph_pkg::DATA_W-1:0] reg_rdata_i
);
  import periph_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;

  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (req_i) state_d = ST_ACCESS;
      ST_ACCESS: state_d = ST_RESP;
      ST_RESP:   state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, held through the strobe cycle
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == ST_ACCESS) begin
      rdata_q <= reg_rdata_i;
    end
  end

  assign gnt_o       = (state_q == ST_IDLE);
  assign reg_valid_o = (state_q == ST_ACCESS);
  assign reg_write_o = we_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign rvalid_o    = (state_q == ST_RESP);
  assign rdata_o     = rdata_q;

  // One response per request, never back to back
  assert property (@(posedge clk_i) disable iff (reset_i) rvalid_o |=> !rvalid_o)
    else $error("rvalid_o high in consecutive cycles");

  assert property (@(posedge clk_i) disable iff (reset_i) !(gnt_o && reg_valid_o))
    else $error("grant given while a strobe is active");

endmodule

`default_nettype wire

//--- src/periph_reg_demux.sv
/*
  Register demux: decodes the peripheral select from the address,
  steers the strobe and returns the selected read data
*/
`default_nettype none

module periph_reg_demux (
  input  logic                          reg_valid_i,
  input  logic                          reg_write_i,
  input  logic [periph_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [periph_pkg::DATA_W-1:0] plic_rdata_i,
  input  logic [periph_pkg::DATA_W-1:0] gpio_rdata_i,
  input  logic [periph_pkg::DATA_W-1:0] tmr_rdata_i,
  output logic [periph_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                          plic_valid_o,
  output logic                          gpio_valid_o,
  output logic                          tmr_valid_o
);
  import periph_pkg::*;

  periph_sel_e sel;

  // Two select bits directly above the offset field
  assign sel = periph_sel_e'(reg_addr_i[OFF_W+1:OFF_W]);

  assign plic_valid_o = reg_valid_i && (sel == SEL_PLIC);
  assign gpio_valid_o = reg_valid_i && (sel == SEL_GPIO);
  assign tmr_valid_o  = reg_valid_i && (sel == SEL_TIMER);

  // Writes return zero, as does the unmapped window
  always_comb begin
    reg_rdata_o = '0;
    if (!reg_write_i) begin
      case (sel)
        SEL_PLIC:  reg_rdata_o = plic_rdata_i;
        SEL_GPIO:  reg_rdata_o = gpio_rdata_i;
        SEL_TIMER: reg_rdata_o = tmr_rdata_i;
        default:   reg_rdata_o = '0;
      endcase
    end
  end

  always_comb begin
    assert ($onehot0({plic_valid_o, gpio_valid_o, tmr_valid_o}))
      else $error("more than one peripheral strobed");
  end

endmodule

`default_nettype wire

//--- src/irq_ctrl.sv
/*
  PLIC-like interrupt controller with level gateways, enable mask,
  claim/complete through one register and a software interrupt bit
*/
`default_nettype none

module irq_ctrl #(
  parameter int n_ext_irq = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           reg_valid_i,
  input  logic                           reg_write_i,
  input  logic [periph_pkg::OFF_W-1:0]   reg_addr_i,
  input  logic [periph_pkg::DATA_W-1:0]  reg_wdata_i,
  output logic [periph_pkg::DATA_W-1:0]  reg_rdata_o,
  input  logic [periph_pkg::GPIO_W-1:0]  gpio_intr_i,
  input  logic [n_ext_irq-1:0]           ext_irq_i,
  output logic                           irq_o,
  output logic                           msip_o
);
  import periph_pkg::*;

  logic [NUM_SRC-1:0]  src;
  logic [NUM_SRC-1:0]  pending_q;
  logic [NUM_SRC-1:0]  pending_d;
  logic [NUM_SRC-1:0]  enable_q;
  logic [NUM_SRC-1:0]  in_service_q;
  logic                msip_q;
  logic [SRC_ID_W-1:0] claim_id;
  logic                claim_rd;
  logic                complete_wr;
  logic [SRC_ID_W-1:0] complete_id;

  // Source 0 stays tied low
  always_comb begin
    src = '0;
    src[GPIO_IRQ_BASE +: GPIO_W]   = gpio_intr_i;
    src[EXT_IRQ_BASE +: n_ext_irq] = ext_irq_i;
  end

  // Lowest pending enabled ID wins
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) claim_id = SRC_ID_W'(i);
    end
  end

  assign claim_rd    = reg_valid_i && !reg_write_i && (reg_addr_i == PLIC_CLAIM)
                       && (claim_id != '0);
  assign complete_wr = reg_valid_i && reg_write_i && (reg_addr_i == PLIC_CLAIM);
  assign complete_id = reg_wdata_i[SRC_ID_W-1:0];

  // Level gateway, a source in service cannot pend again
  always_comb begin
    pending_d = pending_q | (src & ~in_service_q);
    if (claim_rd) pending_d[claim_id] = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q    <= '0;
      enable_q     <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
    end else begin
      pending_q <= pending_d;
      if (claim_rd) in_service_q[claim_id] <= 1'b1;
      if (complete_wr) in_service_q[complete_id] <= 1'b0;
      if (reg_valid_i && reg_write_i && reg_addr_i == PLIC_ENABLE) begin
        enable_q <= reg_wdata_i[NUM_SRC-1:0];
      end
      if (reg_valid_i && reg_write_i && reg_addr_i == PLIC_MSIP) begin
        msip_q <= reg_wdata_i[0];
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      PLIC_PENDING: reg_rdata_o = DATA_W'(pending_q);
      PLIC_ENABLE:  reg_rdata_o = DATA_W'(enable_q);
      PLIC_CLAIM:   reg_rdata_o = DATA_W'(claim_id);
      PLIC_MSIP:    reg_rdata_o = DATA_W'(msip_q);
      default:      reg_rdata_o = '0;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

  assert property (@(posedge clk_i) disable iff (reset_i) !pending_q[0])
    else $error("source 0 became pending");

endmodule

`default_nettype wire

//--- src/gpio_ctrl.sv
/*
  GPIO block: output and output-enable registers, synchronized inputs
  and rising-edge interrupts with write-one-to-clear status
*/
`default_nettype none

module gpio_ctrl (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          reg_valid_i,
  input  logic                          reg_write_i,
  input  logic [periph_pkg::OFF_W-1:0]  reg_addr_i,
  input  logic [periph_pkg::DATA_W-1:0] reg_wdata_i,
  output logic [periph_pkg::DATA_W-1:0] reg_rdata_o,
  input  logic [periph_pkg::GPIO_W-1:0] gpio_i,
  output logic [periph_pkg::GPIO_W-1:0] gpio_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_en_o,
  output logic [periph_pkg::GPIO_W-1:0] intr_o
);
  import periph_pkg::*;

  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] intr_state_q;
  logic [GPIO_W-1:0] rise;
  logic              wr;

  assign wr   = reg_valid_i && reg_write_i;
  assign rise = sync2_q & ~prev_q & intr_en_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q      <= '0;
      sync2_q      <= '0;
      prev_q       <= '0;
      out_q        <= '0;
      oe_q         <= '0;
      intr_en_q    <= '0;
      intr_state_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && reg_addr_i == GPIO_OUT) out_q <= reg_wdata_i[GPIO_W-1:0];
      if (wr && reg_addr_i == GPIO_OE) oe_q <= reg_wdata_i[GPIO_W-1:0];
      if (wr && reg_addr_i == GPIO_INTR_EN) intr_en_q <= reg_wdata_i[GPIO_W-1:0];
      // A new edge wins over a clear in the same cycle
      if (wr && reg_addr_i == GPIO_INTR_STATE) begin
        intr_state_q <= (intr_state_q & ~reg_wdata_i[GPIO_W-1:0]) | rise;
      end else begin
        intr_state_q <= intr_state_q | rise;
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      GPIO_IN:         reg_rdata_o = DATA_W'(sync2_q);
      GPIO_OUT:        reg_rdata_o = DATA_W'(out_q);
      GPIO_OE:         reg_rdata_o = DATA_W'(oe_q);
      GPIO_INTR_EN:    reg_rdata_o = DATA_W'(intr_en_q);
      GPIO_INTR_STATE: reg_rdata_o = DATA_W'(intr_state_q);
      default:         reg_rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = intr_state_q;

endmodule

`default_nettype wire

//--- src/mtimer.sv
/*
  Timer with a prescaled 32-bit counter and two compare interrupts
*/
`default_nettype none

module mtimer (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          reg_valid_i,
  input  logic                          reg_write_i,
  input  logic [periph_pkg::OFF_W-1:0]  reg_addr_i,
  input  logic [periph_pkg::DATA_W-1:0] reg_wdata_i,
  output logic [periph_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                          timer_0_intr_o,
  output logic                          timer_1_intr_o
);
  import periph_pkg::*;

  logic              enable_q;
  logic [DATA_W-1:0] prescale_q;
  logic [DATA_W-1:0] presc_cnt_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp0_q;
  logic [DATA_W-1:0] cmp1_q;
  logic              tick;
  logic              wr;

  assign wr   = reg_valid_i && reg_write_i;
  assign tick = enable_q && (presc_cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q    <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      count_q     <= '0;
      cmp0_q      <= '1;
      cmp1_q      <= '1;
    end else begin
      // Prescaler reloads while stopped and after each tick
      if (!enable_q || tick) presc_cnt_q <= prescale_q;
      else presc_cnt_q <= presc_cnt_q - 1'b1;

      if (wr && reg_addr_i == TMR_COUNT) count_q <= reg_wdata_i;
      else if (tick) count_q <= count_q + 1'b1;

      if (wr && reg_addr_i == TMR_CTRL) enable_q <= reg_wdata_i[0];
      if (wr && reg_addr_i == TMR_PRESCALE) prescale_q <= reg_wdata_i;
      if (wr && reg_addr_i == TMR_CMP0) cmp0_q <= reg_wdata_i;
      if (wr && reg_addr_i == TMR_CMP1) cmp1_q <= reg_wdata_i;
    end
  end

  always_comb begin
    case (reg_addr_i)
      TMR_CTRL:     reg_rdata_o = DATA_W'(enable_q);
      TMR_PRESCALE: reg_rdata_o = prescale_q;
      TMR_COUNT:    reg_rdata_o = count_q;
      TMR_CMP0:     reg_rdata_o = cmp0_q;
      TMR_CMP1:     reg_rdata_o = cmp1_q;
      default:      reg_rdata_o = '0;
    endcase
  end

  assign timer_0_intr_o = enable_q && (count_q >= cmp0_q);
  assign timer_1_intr_o = enable_q && (count_q >= cmp1_q);

endmodule

`default_nettype wire

//--- src/periph_subsys.sv
/*
  Peripheral subsystem top: OBI bridge, address demux, interrupt
  controller, GPIO and timer
*/
`default_nettype none

module periph_subsys #(
  parameter int n_ext_irq = 4
) (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // OBI slave port
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [periph_pkg::ADDR_W-1:0] addr_i,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,

  // Interrupt controller
  input  logic [n_ext_irq-1:0]          ext_irq_i,
  output logic                          irq_plic_o,
  output logic                          msip_o,

  // GPIO pins
  input  logic [periph_pkg::GPIO_W-1:0] gpio_i,
  output logic [periph_pkg::GPIO_W-1:0] gpio_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_en_o,

  // Timer
  output logic                          timer_0_intr_o,
  output logic                          timer_1_intr_o
);
  import periph_pkg::*;

  logic              reg_valid;
  logic              reg_write;
  logic [ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0] reg_wdata;
  logic [DATA_W-1:0] reg_rdata;

  logic              plic_valid;
  logic              gpio_valid;
  logic              tmr_valid;
  logic [DATA_W-1:0] plic_rdata;
  logic [DATA_W-1:0] gpio_rdata;
  logic [DATA_W-1:0] tmr_rdata;

  logic [GPIO_W-1:0] gpio_intr;

  obi_reg_bridge obi_reg_bridge_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  periph_reg_demux periph_reg_demux_inst (
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .plic_rdata_i (plic_rdata),
    .gpio_rdata_i (gpio_rdata),
    .tmr_rdata_i  (tmr_rdata),
    .reg_rdata_o  (reg_rdata),
    .plic_valid_o (plic_valid),
    .gpio_valid_o (gpio_valid),
    .tmr_valid_o  (tmr_valid)
  );

  irq_ctrl #(
    .n_ext_irq (n_ext_irq)
  ) irq_ctrl_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_valid_i (plic_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr[OFF_W-1:0]),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (plic_rdata),
    .gpio_intr_i (gpio_intr),
    .ext_irq_i   (ext_irq_i),
    .irq_o       (irq_plic_o),
    .msip_o      (msip_o)
  );

  gpio_ctrl gpio_ctrl_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_valid_i (gpio_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr[OFF_W-1:0]),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (gpio_rdata),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_o      (gpio_intr)
  );

  mtimer mtimer_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .reg_valid_i    (tmr_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr[OFF_W-1:0]),
    .reg_wdata_i    (reg_wdata),
    .reg_rdata_o    (tmr_rdata),
    .timer_0_intr_o (timer_0_intr_o),
    .timer_1_intr_o (timer_1_intr_o)
  );

  // External lines must fit above the GPIO sources
  assert property (@(posedge clk_i) (n_ext_irq + EXT_IRQ_BASE) <= NUM_SRC)
    else $error("n_ext_irq too large for the source map");

endmodule

`default_nettype wire

//--- tests/periph_subsys_tb.sv
/*
  Testbench for the peripheral subsystem: bus timing, decode, GPIO edges,
  interrupt claim/complete, software interrupt and timer compare
*/
`default_nettype none

module periph_subsys_tb;
  import periph_pkg::*;

  localparam int          MAX_CYCLES = 20000;
  localparam logic [31:0] PLIC_BASE  = 32'h0000;
  localparam logic [31:0] GPIO_BASE  = 32'h1000;
  localparam logic [31:0] TMR_BASE   = 32'h2000;
  localparam logic [31:0] NONE_BASE  = 32'h3000;

  logic        clk_i;
  logic        reset_i;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  ext_irq_i;
  logic [7:0]  gpio_i;
  logic        gnt_o;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic        irq_plic_o;
  logic        msip_o;
  logic [7:0]  gpio_o;
  logic [7:0]  gpio_en_o;
  logic        timer_0_intr_o;
  logic        timer_1_intr_o;

  int          errors = 0;
  int          errors_at_start = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          cycles = 0;
  logic        strobe_t0;
  logic        strobe_t1;
  logic [31:0] rd;
  logic [31:0] val;
  logic [31:0] cmp0;
  logic [31:0] cmp1;

  periph_subsys #(
    .n_ext_irq (4)
  ) periph_subsys_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .ext_irq_i      (ext_irq_i),
    .irq_plic_o     (irq_plic_o),
    .msip_o         (msip_o),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o),
    .gpio_en_o      (gpio_en_o),
    .timer_0_intr_o (timer_0_intr_o),
    .timer_1_intr_o (timer_1_intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Grant stays low for two edges and comes back right after rvalid
  assert property (@(posedge clk_i) disable iff (reset_i) $fell(gnt_o) |=> !gnt_o)
    else begin
      errors++;
      $display("Assertion failed at %0t: gnt_o returned too early", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i) rvalid_o |=> (gnt_o && !rvalid_o))
    else begin
      errors++;
      $display("Assertion failed at %0t: rvalid_o not followed by grant", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i) rvalid_o |-> !gnt_o)
    else begin
      errors++;
      $display("Assertion failed at %0t: gnt_o high together with rvalid_o", $time);
    end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        errors++;
        $display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      end
  endtask

  // One OBI transfer; outputs are sampled on falling edges
  task automatic bus_xfer(input logic write, input logic [31:0] addr,
                          input logic [31:0] data, output logic [31:0] rdata);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= write;
    addr_i  <= addr;
    wdata_i <= data;
    @(negedge clk_i);
    while (!gnt_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    // Strobe cycle
    @(negedge clk_i);
    check_val("gnt_o", 32'd0, 32'(gnt_o));
    check_val("reg_valid", 32'd1, 32'(periph_subsys_inst.reg_valid));
    check_val("rvalid_o", 32'd0, 32'(rvalid_o));
    strobe_t0 = timer_0_intr_o;
    strobe_t1 = timer_1_intr_o;
    @(negedge clk_i);
    check_val("rvalid_o", 32'd1, 32'(rvalid_o));
    rdata = rdata_o;
    if (write) check_val("rdata_o", 32'd0, rdata_o);
    @(negedge clk_i);
    check_val("rvalid_o", 32'd0, 32'(rvalid_o));
    check_val("gnt_o", 32'd1, 32'(gnt_o));
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_xfer(1'b1, addr, data, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_xfer(1'b0, addr, 32'd0, data);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                             input string name);
    logic [31:0] data;
    bus_read(addr, data);
    check_val(name, exp, data);
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      pass_count++;
      $display("PASS: %s", name);
    end else begin
      fail_count++;
      $display("FAIL: %s (%0d errors)", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    void'($urandom(72855));
    reset_i   = 1'b1;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    ext_irq_i = '0;
    gpio_i    = '0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);

    check_val("gnt_o", 32'd1, 32'(gnt_o));
    check_val("rvalid_o", 32'd0, 32'(rvalid_o));
    check_val("irq_plic_o", 32'd0, 32'(irq_plic_o));
    check_val("msip_o", 32'd0, 32'(msip_o));
    check_val("gpio_o", 32'd0, 32'(gpio_o));
    check_val("gpio_en_o", 32'd0, 32'(gpio_en_o));
    check_val("timer_0_intr_o", 32'd0, 32'(timer_0_intr_o));
    check_val("timer_1_intr_o", 32'd0, 32'(timer_1_intr_o));
    read_expect(TMR_BASE | 32'(TMR_CMP0), 32'hFFFF_FFFF, "TMR_CMP0");
    read_expect(TMR_BASE | 32'(TMR_CMP1), 32'hFFFF_FFFF, "TMR_CMP1");
    read_expect(TMR_BASE | 32'(TMR_COUNT), 32'd0, "TMR_COUNT");
    read_expect(PLIC_BASE | 32'(PLIC_PENDING), 32'd0, "PLIC_PENDING");
    end_test("reset state and bus timing");

    val = $urandom;
    bus_write(GPIO_BASE | 32'(GPIO_OUT), val);
    read_expect(GPIO_BASE | 32'(GPIO_OUT), val & 32'hFF, "GPIO_OUT");
    check_val("gpio_o", val & 32'hFF, 32'(gpio_o));
    val = $urandom;
    bus_write(GPIO_BASE | 32'(GPIO_OE), val);
    check_val("gpio_en_o", val & 32'hFF, 32'(gpio_en_o));
    val = $urandom;
    bus_write(TMR_BASE | 32'(TMR_CMP0), val);
    read_expect(TMR_BASE | 32'(TMR_CMP0), val, "TMR_CMP0");
    val = $urandom;
    bus_write(PLIC_BASE | 32'(PLIC_ENABLE), val);
    read_expect(PLIC_BASE | 32'(PLIC_ENABLE), val & 32'hFFFF, "PLIC_ENABLE");
    bus_write(PLIC_BASE | 32'(PLIC_ENABLE), 32'd0);
    bus_write(NONE_BASE, $urandom);
    read_expect(NONE_BASE, 32'd0, "unmapped read");
    end_test("decode and register access");

    // Pin 2 enabled, pin 3 not
    bus_write(GPIO_BASE | 32'(GPIO_INTR_EN), 32'h04);
    @(posedge clk_i);
    gpio_i <= 8'h0C;
    repeat (3) @(posedge clk_i);
    read_expect(GPIO_BASE | 32'(GPIO_IN), 32'h0C, "GPIO_IN");
    read_expect(GPIO_BASE | 32'(GPIO_INTR_STATE), 32'h04, "GPIO_INTR_STATE");
    bus_write(GPIO_BASE | 32'(GPIO_INTR_STATE), 32'h04);
    read_expect(GPIO_BASE | 32'(GPIO_INTR_STATE), 32'h00, "GPIO_INTR_STATE");
    @(posedge clk_i);
    gpio_i <= 8'h00;
    repeat (3) @(posedge clk_i);
    end_test("GPIO input and edge interrupt");

    @(posedge clk_i);
    gpio_i    <= 8'h04;
    ext_irq_i <= 4'b0010;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_val("irq_plic_o", 32'd0, 32'(irq_plic_o));
    bus_write(PLIC_BASE | 32'(PLIC_ENABLE), (32'd1 << 3) | (32'd1 << 10));
    check_val("irq_plic_o", 32'd1, 32'(irq_plic_o));
    read_expect(PLIC_BASE | 32'(PLIC_CLAIM), 32'd3, "PLIC_CLAIM");
    bus_write(GPIO_BASE | 32'(GPIO_INTR_STATE), 32'h04);
    bus_write(PLIC_BASE | 32'(PLIC_CLAIM), 32'd3);
    read_expect(PLIC_BASE | 32'(PLIC_CLAIM), 32'd10, "PLIC_CLAIM");
    @(posedge clk_i);
    ext_irq_i <= 4'b0000;
    bus_write(PLIC_BASE | 32'(PLIC_CLAIM), 32'd10);
    check_val("irq_plic_o", 32'd0, 32'(irq_plic_o));
    read_expect(PLIC_BASE | 32'(PLIC_CLAIM), 32'd0, "PLIC_CLAIM");
    end_test("interrupt claim and complete");

    bus_write(PLIC_BASE | 32'(PLIC_MSIP), 32'd1);
    check_val("msip_o", 32'd1, 32'(msip_o));
    bus_write(PLIC_BASE | 32'(PLIC_MSIP), 32'd0);
    check_val("msip_o", 32'd0, 32'(msip_o));
    end_test("software interrupt");

    cmp0 = $urandom_range(16, 6);
    cmp1 = cmp0 + $urandom_range(12, 4);
    bus_write(TMR_BASE | 32'(TMR_PRESCALE), $urandom_range(3, 0));
    bus_write(TMR_BASE | 32'(TMR_CMP0), cmp0);
    bus_write(TMR_BASE | 32'(TMR_CMP1), cmp1);
    bus_write(TMR_BASE | 32'(TMR_COUNT), 32'd0);
    bus_write(TMR_BASE | 32'(TMR_CTRL), 32'd1);
    rd = '0;
    // Interrupts seen in the strobe cycle match the count read there
    while (rd <= cmp1 + 2) begin
      bus_read(TMR_BASE | 32'(TMR_COUNT), rd);
      check_val("timer_0_intr_o", 32'(rd >= cmp0), 32'(strobe_t0));
      check_val("timer_1_intr_o", 32'(rd >= cmp1), 32'(strobe_t1));
    end
    bus_write(TMR_BASE | 32'(TMR_CTRL), 32'd0);
    check_val("timer_0_intr_o", 32'd0, 32'(timer_0_intr_o));
    check_val("timer_1_intr_o", 32'd0, 32'(timer_1_intr_o));
    end_test("timer compare");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (errors == 0 && fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- periph_subsys.f
src/periph_pkg.sv
src/obi_reg_bridge.sv
src/periph_reg_demux.sv
src/irq_ctrl.sv
src/gpio_ctrl.sv
src/mtimer.sv
src/periph_subsys.sv
tests/periph_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the periph_subsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_subsys_tb -f periph_subsys.f -o periph_subsys_sim; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/periph_subsys_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi

echo "Pass message not found"
exit 1
